// ==== hw/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    //////////////////////////////////////////////////
    // frame and kernel geometry
    //////////////////////////////////////////////////
    localparam int IMG_W       = 12;
    localparam int IMG_H       = 12;
    localparam int KERNEL      = 5;
    localparam int OUT_W       = IMG_W - KERNEL + 1;
    localparam int OUT_H       = IMG_H - KERNEL + 1;
    localparam int NUM_FILTERS = 2;
    // multiply, row sum, row total plus bias
    localparam int MAC_LATENCY = 3;

    // counter widths for pixel position and output index
    localparam int COL_W     = $clog2(IMG_W);
    localparam int ROW_W     = $clog2(IMG_H);
    localparam int OUT_CNT_W = $clog2(OUT_W * OUT_H);

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////
    typedef logic        [7:0]  pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [15:0] bias_t;
    // 25 products of 17 bits plus bias fit in 24 bits
    typedef logic signed [23:0] acc_t;
    typedef logic signed [15:0] feature_t;

    // window indexed [row][col], col 0 is the left (oldest) column
    typedef pixel_t [KERNEL-1:0][KERNEL-1:0] window_t;
    typedef acc_t     [NUM_FILTERS-1:0] acc_vec_t;
    typedef feature_t [NUM_FILTERS-1:0] feature_vec_t;

    // saturation limits of a 16 bit feature
    localparam feature_t FEAT_MAX = 16'sh7fff;
    localparam feature_t FEAT_MIN = 16'sh8000;

    //////////////////////////////////////////////////
    // trained parameters, [filter][row][col]
    //////////////////////////////////////////////////
    localparam weight_t WEIGHTS [NUM_FILTERS][KERNEL][KERNEL] = '{
        // filter 0: centre weighted blob, saturates high on bright input
        '{'{  3,  -5,  12,  -5,   3},
          '{ -5,  20,  45,  20,  -5},
          '{ 12,  45, 127,  45,  12},
          '{ -5,  20,  45,  20,  -5},
          '{  3,  -5,  12,  -5,   3}},
        // filter 1: horizontal gradient, near balanced
        '{'{-128, -40,   0,  40, 127},
          '{ -90, -30,   0,  30,  90},
          '{ -75, -25,   0,  25,  75},
          '{ -90, -30,   0,  30,  90},
          '{-128, -40,   0,  40, 126}}
    };

    localparam bias_t BIASES [NUM_FILTERS] = '{16'sd300, -16'sd150};

endpackage

`default_nettype wire

// ==== hw/conv_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_window
    import conv_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_pix_valid,
    input  pixel_t  i_pix,
    output logic    o_win_valid,
    output window_t o_win
);

    //////////////////////////////////////////////////
    // storage and position
    //////////////////////////////////////////////////

    // four previous rows, index 0 holds the oldest row
    // entry [r][c] is the pixel of row (row_cnt - KERNEL + 1 + r) at column c
    pixel_t lines [KERNEL-1][IMG_W];

    // position of the pixel being accepted
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;

    logic col_last;
    logic row_last;
    // incoming pixel is the bottom right corner of a full window
    logic win_full;

    assign col_last = (col_cnt == COL_W'(IMG_W - 1));
    assign row_last = (row_cnt == ROW_W'(IMG_H - 1));
    assign win_full = (col_cnt >= COL_W'(KERNEL - 1)) &&
                      (row_cnt >= ROW_W'(KERNEL - 1));

    //////////////////////////////////////////////////
    // raster position counters
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_pix_valid) begin
            if (col_last) begin
                // end of row, wrap column and step row
                col_cnt <= '0;
                if (row_last) begin
                    // end of frame, next pixel starts a new frame
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // line buffer
    //////////////////////////////////////////////////

    // only the column being accepted moves
    // each entry climbs one row, the new pixel lands in the youngest row
    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            for (int r = 0; r < KERNEL - 2; r++) begin
                lines[r][col_cnt] <= lines[r+1][col_cnt];
            end
            lines[KERNEL-2][col_cnt] <= i_pix;
        end
    end

    //////////////////////////////////////////////////
    // 5x5 window register
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_pix_valid) begin
            // shift every row one column to the left
            for (int r = 0; r < KERNEL; r++) begin
                for (int c = 0; c < KERNEL - 1; c++) begin
                    o_win[r][c] <= o_win[r][c+1];
                end
            end
            // new right column, upper rows come from the line buffer
            for (int r = 0; r < KERNEL - 1; r++) begin
                o_win[r][KERNEL-1] <= lines[r][col_cnt];
            end
            // bottom right is the incoming pixel
            o_win[KERNEL-1][KERNEL-1] <= i_pix;
        end
    end

    // one pulse per complete window
    // columns below KERNEL-1 would mix the end of the previous row
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= i_pix_valid && win_full;
        end
    end

endmodule

`default_nettype wire

// ==== hw/conv_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mac
    import conv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_win_valid,
    input  window_t  i_win,
    output logic     o_sum_valid,
    output acc_vec_t o_sums
);

    //////////////////////////////////////////////////
    // pipeline registers
    //////////////////////////////////////////////////

    // stage 1, one product per tap and filter
    acc_t prod [NUM_FILTERS][KERNEL][KERNEL];
    // stage 2, one sum per kernel row and filter
    acc_t row_sum [NUM_FILTERS][KERNEL];

    // next values of stage 2 and stage 3
    acc_t     row_sum_d [NUM_FILTERS][KERNEL];
    acc_vec_t total_d;

    // valid travels alongside the data, bit 0 marks stage 1 full
    logic [MAC_LATENCY-1:0] valid_sr;

    //////////////////////////////////////////////////
    // stage 1: multiply
    //////////////////////////////////////////////////

    // pixel is unsigned, zero extend before the signed multiply
    always_ff @(posedge i_clk) begin
        if (i_win_valid) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                for (int r = 0; r < KERNEL; r++) begin
                    for (int c = 0; c < KERNEL; c++) begin
                        prod[f][r][c] <= acc_t'($signed({1'b0, i_win[r][c]}) *
                                                 WEIGHTS[f][r][c]);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stage 2: row sums
    //////////////////////////////////////////////////
    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int r = 0; r < KERNEL; r++) begin
                row_sum_d[f][r] = '0;
                for (int c = 0; c < KERNEL; c++) begin
                    row_sum_d[f][r] = row_sum_d[f][r] + prod[f][r][c];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (valid_sr[0]) begin
            row_sum <= row_sum_d;
        end
    end

    //////////////////////////////////////////////////
    // stage 3: row total plus bias
    //////////////////////////////////////////////////

    // bias is sign extended into the accumulator
    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            total_d[f] = acc_t'(BIASES[f]);
            for (int r = 0; r < KERNEL; r++) begin
                total_d[f] = total_d[f] + row_sum[f][r];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (valid_sr[1]) begin
            o_sums <= total_d;
        end
    end

    // back to back windows each get their own bit
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[MAC_LATENCY-2:0], i_win_valid};
        end
    end

    assign o_sum_valid = valid_sr[MAC_LATENCY-1];

endmodule

`default_nettype wire

// ==== hw/conv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_result
    import conv_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_sum_valid,
    input  acc_vec_t     i_sums,
    output logic         o_feat_valid,
    output feature_vec_t o_feats,
    output logic         o_last
);

    // index of the next output within the frame
    logic [OUT_CNT_W-1:0] out_cnt;
    logic                 frame_end;

    assign frame_end = (out_cnt == OUT_CNT_W'(OUT_W * OUT_H - 1));

    // clamp a wide sum into the 16 bit feature range
    function automatic feature_t saturate(input acc_t value);
        if (value > acc_t'(FEAT_MAX)) begin
            return FEAT_MAX;
        end else if (value < acc_t'(FEAT_MIN)) begin
            return FEAT_MIN;
        end
        return feature_t'(value);
    endfunction

    //////////////////////////////////////////////////
    // control: valid, frame position, last mark
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_feat_valid <= 1'b0;
            o_last       <= 1'b0;
            out_cnt      <= '0;
        end else begin
            o_feat_valid <= i_sum_valid;
            o_last       <= i_sum_valid && frame_end;
            if (i_sum_valid) begin
                out_cnt <= frame_end ? '0 : out_cnt + 1'b1;
            end
        end
    end

    // saturated features, held until the next result
    always_ff @(posedge i_clk) begin
        if (i_sum_valid) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                o_feats[f] <= saturate(i_sums[f]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_top
    import conv_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_pix_valid,
    input  pixel_t       i_pix,
    output logic         o_feat_valid,
    output feature_vec_t o_feats,
    output logic         o_last
);

    //////////////////////////////////////////////////
    // decode -> execute
    //////////////////////////////////////////////////
    logic    win_valid;
    window_t win;

    // execute -> result
    logic     sum_valid;
    acc_vec_t sums;

    // line buffer and window, one cycle
    conv_window u_window (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win_valid (win_valid),
        .o_win       (win)
    );

    // multiply and adder tree, MAC_LATENCY cycles
    conv_mac u_mac (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_win_valid (win_valid),
        .i_win       (win),
        .o_sum_valid (sum_valid),
        .o_sums      (sums)
    );

    // saturate and mark frame end, one cycle
    conv_result u_result (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_sum_valid  (sum_valid),
        .i_sums       (sums),
        .o_feat_valid (o_feat_valid),
        .o_feats      (o_feats),
        .o_last       (o_last)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clk
);

    // 20 ns period, starts low
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== verification/conv_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_assertions (
    input logic i_clk,
    input logic i_rst,
    input logic i_pix_valid,
    input logic i_win_valid,
    input logic i_feat_valid,
    input logic i_last
);

    // failed assertions so far, read by the testbench monitor
    int error_count = 0;

    // end of frame mark only rides on a valid output
    last_with_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        i_last |-> i_feat_valid)
    else begin
        $error("o_last high without o_feat_valid");
        error_count++;
    end

    // execute plus result stage, fixed 4 cycles
    window_to_output: assert property (@(posedge i_clk) disable iff (i_rst)
        i_feat_valid == $past(i_win_valid, 4))
    else begin
        $error("o_feat_valid is not win_valid delayed by 4 cycles");
        error_count++;
    end

    // synchronous reset clears the output strobes on the next edge
    quiet_in_reset: assert property (@(posedge i_clk)
        i_rst |=> (!i_feat_valid && !i_last))
    else begin
        $error("output strobe high during reset");
        error_count++;
    end

    // a window needs a pixel on the edge before
    window_needs_pixel: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(i_win_valid) |-> $past(i_pix_valid))
    else begin
        $error("win_valid rose without an accepted pixel");
        error_count++;
    end

endmodule

bind conv_top conv_assertions u_conv_assertions (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_pix_valid  (i_pix_valid),
    .i_win_valid  (win_valid),
    .i_feat_valid (o_feat_valid),
    .i_last       (o_last)
);

`default_nettype wire

// ==== verification/tb_conv.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv
    import conv_pkg::*;
();

    // 6 frames, at most one idle cycle per pixel, plus slack for reset and drain
    localparam int TIMEOUT_CYCLES = 6 * IMG_W * IMG_H * 2 + 200;
    localparam int FRAME_PIX      = IMG_W * IMG_H;

    logic         i_clk;
    logic         i_rst;
    logic         i_pix_valid;
    pixel_t       i_pix;
    logic         o_feat_valid;
    feature_vec_t o_feats;
    logic         o_last;

    // pixels of the frame being sent, raster order
    pixel_t frame_pix [FRAME_PIX];

    // expected outputs, one entry per o_feat_valid
    feature_vec_t exp_feats [$];
    logic         exp_last [$];
    string        exp_name [$];

    bit          check_enable = 1'b1;
    int unsigned cycle_count  = 0;

    tb_clock u_clock (.o_clk(i_clk));

    conv_top i_dut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .o_feat_valid (o_feat_valid),
        .o_feats      (o_feats),
        .o_last       (o_last)
    );

    //////////////////////////////////////////////////
    // failure reporting and compare tasks
    //////////////////////////////////////////////////
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_feature(input string name, input feature_t exp, input feature_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s o_last: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // bias plus window dot product, clamped to 16 bits
    function automatic feature_t model_feature(input int f, input int oy, input int ox);
        int sum;
        sum = int'(BIASES[f]);
        for (int r = 0; r < KERNEL; r++) begin
            for (int c = 0; c < KERNEL; c++) begin
                sum += int'(frame_pix[(oy + r) * IMG_W + ox + c]) * int'(WEIGHTS[f][r][c]);
            end
        end
        if (sum > int'(FEAT_MAX)) begin
            return FEAT_MAX;
        end else if (sum < int'(FEAT_MIN)) begin
            return FEAT_MIN;
        end
        return feature_t'(sum);
    endfunction

    task automatic queue_expected(input string name);
        feature_vec_t feats;
        for (int oy = 0; oy < OUT_H; oy++) begin
            for (int ox = 0; ox < OUT_W; ox++) begin
                for (int f = 0; f < NUM_FILTERS; f++) begin
                    feats[f] = model_feature(f, oy, ox);
                end
                exp_feats.push_back(feats);
                exp_last.push_back((oy == OUT_H - 1) && (ox == OUT_W - 1));
                exp_name.push_back(name);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic fill_random();
        for (int i = 0; i < FRAME_PIX; i++) begin
            frame_pix[i] = pixel_t'($urandom_range(255, 0));
        end
    endtask

    task automatic fill_const(input pixel_t value);
        for (int i = 0; i < FRAME_PIX; i++) begin
            frame_pix[i] = value;
        end
    endtask

    // valid stays high at the end so frames run back to back
    task automatic send_pixels(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            if (gaps && ($urandom_range(1, 0) == 0)) begin
                @(posedge i_clk);
                i_pix_valid <= 1'b0;
            end
            @(posedge i_clk);
            i_pix_valid <= 1'b1;
            i_pix       <= frame_pix[i];
        end
    endtask

    // stop the stream and give the pipeline time to empty
    task automatic drain_outputs();
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_pix_valid <= 1'b0;
        while ((exp_feats.size() != 0) && (waited < 20)) begin
            @(posedge i_clk);
            waited++;
        end
        if (exp_feats.size() != 0) begin
            $display("ERROR: %0d expected outputs never arrived", exp_feats.size());
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // output monitor and timeout
    //////////////////////////////////////////////////

    // each output is compared with the head of the queue
    always @(negedge i_clk) begin : monitor
        feature_vec_t exp_v;
        logic         exp_l;
        string        name;
        if (i_dut.u_conv_assertions.error_count != 0) begin
            $display("ERROR: a protocol assertion failed");
            abort_run();
        end
        if (!i_rst && check_enable && o_feat_valid) begin
            if (exp_feats.size() == 0) begin
                $display("ERROR: output arrived with no expected value queued");
                abort_run();
            end
            exp_v = exp_feats.pop_front();
            exp_l = exp_last.pop_front();
            name  = exp_name.pop_front();
            for (int f = 0; f < NUM_FILTERS; f++) begin
                check_feature($sformatf("%s filter %0d", name, f), exp_v[f], o_feats[f]);
            end
            check_last(name, exp_l, o_last);
        end
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles", cycle_count);
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(71));
        i_rst       = 1'b1;
        i_pix_valid = 1'b0;
        i_pix       = '0;
        repeat (16) @(posedge i_clk);
        i_rst <= 1'b0;

        // four frames back to back, o_last must hit each 64th output
        fill_random();
        queue_expected("random_no_gaps");
        send_pixels(FRAME_PIX, 1'b0);
        fill_random();
        queue_expected("random_gaps");
        send_pixels(FRAME_PIX, 1'b1);
        // bright frame saturates filter 0
        fill_const(8'hff);
        queue_expected("all_255");
        send_pixels(FRAME_PIX, 1'b0);
        // dark frame leaves only the bias
        fill_const(8'h00);
        queue_expected("all_zero");
        send_pixels(FRAME_PIX, 1'b0);
        drain_outputs();

        // partial frame, cut by reset and not checked
        check_enable = 1'b0;
        fill_random();
        send_pixels(FRAME_PIX / 2 + 8, 1'b0);
        @(posedge i_clk);
        i_pix_valid <= 1'b0;
        i_rst       <= 1'b1;
        repeat (16) @(posedge i_clk);
        i_rst        <= 1'b0;
        check_enable = 1'b1;

        // first frame after reset checked from its first output
        fill_random();
        queue_expected("after_reset");
        send_pixels(FRAME_PIX, 1'b1);
        drain_outputs();
        repeat (4) @(posedge i_clk);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/conv_pkg.sv
hw/conv_window.sv
hw/conv_mac.sv
hw/conv_result.sv
hw/conv_top.sv
verification/tb_clock.sv
verification/conv_assertions.sv
verification/tb_conv.sv

// ==== Bender.yml ====
package:
  name: conv_engine

sources:
  - files:
      - hw/conv_pkg.sv
      - hw/conv_window.sv
      - hw/conv_mac.sv
      - hw/conv_result.sv
      - hw/conv_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/conv_assertions.sv
      - verification/tb_conv.sv
